/* Bender.yml */
package:
  name: packet_scheduler

sources:
  - rtl/sched_pkg.sv
  - rtl/desc_fifo.sv
  - rtl/slot_loader.sv
  - rtl/core_reset_seq.sv
  - rtl/core_selector.sv
  - rtl/port_tagger.sv
  - rtl/packet_scheduler.sv
  - target: test
    files:
      - bench/sched_assert.sv
      - bench/tb_packet_scheduler.sv

/* bench/sched_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_assert #(
  parameter int PORT_COUNT = 2
) (
  input logic                              clk,
  input logic                              rst,
  input logic [PORT_COUNT-1:0]             rx_tvalid,
  input logic [PORT_COUNT-1:0]             rx_tready,
  input logic [PORT_COUNT-1:0]             rx_tlast,
  input sched_pkg::dest_t [PORT_COUNT-1:0] data_tdest,
  input sched_pkg::word_t                  ctrl_in_tdata,
  input logic                              ctrl_in_tvalid,
  input logic                              ctrl_in_tready,
  input sched_pkg::word_t                  ctrl_out_tdata,
  input sched_pkg::core_id_t               ctrl_out_tdest,
  input logic                              ctrl_out_tvalid,
  input logic                              ctrl_out_tready
);

  import sched_pkg::*;

  logic [7:0] in_type;

  assign in_type = ctrl_in_tdata[63:MSG_TYPE_LSB];

  // A port keeps its destination from one word of a frame to the next
  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    a_dest_held: assert property (@(posedge clk) disable iff (rst)
      rx_tvalid[p] && rx_tready[p] && !rx_tlast[p] |=> $stable(data_tdest[p]))
      else $error("tdest changed inside a frame on port %0d", p);
  end

  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    ctrl_out_tvalid && !ctrl_out_tready |=>
      ctrl_out_tvalid && $stable(ctrl_out_tdata) && $stable(ctrl_out_tdest))
    else $error("control output dropped or changed before acceptance");

  a_known_type: assert property (@(posedge clk) disable iff (rst)
    ctrl_in_tvalid && ctrl_in_tready |->
      in_type == 8'd0 || in_type == 8'd1 || in_type == 8'd4)
    else $error("control word of unknown type accepted");

endmodule

bind packet_scheduler sched_assert #(
  .PORT_COUNT(PORT_COUNT)
) u_assert (
  .clk             (clk),
  .rst             (rst),
  .rx_tvalid       (rx_tvalid),
  .rx_tready       (rx_tready),
  .rx_tlast        (rx_tlast),
  .data_tdest      (data_tdest),
  .ctrl_in_tdata   (ctrl_in_tdata),
  .ctrl_in_tvalid  (ctrl_in_tvalid),
  .ctrl_in_tready  (ctrl_in_tready),
  .ctrl_out_tdata  (ctrl_out_tdata),
  .ctrl_out_tdest  (ctrl_out_tdest),
  .ctrl_out_tvalid (ctrl_out_tvalid),
  .ctrl_out_tready (ctrl_out_tready)
);

`default_nettype wire

/* bench/tb_packet_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_packet_scheduler;

  import sched_pkg::*;

  localparam int PORT_COUNT = 2;
  localparam int CORE_COUNT = 4;
  localparam int SLOT_COUNT = 4;
  localparam int TIMEOUT    = 200;

  logic                   clk;
  logic                   rst;
  word_t [PORT_COUNT-1:0] rx_tdata;
  keep_t [PORT_COUNT-1:0] rx_tkeep;
  logic [PORT_COUNT-1:0]  rx_tvalid;
  logic [PORT_COUNT-1:0]  rx_tready;
  logic [PORT_COUNT-1:0]  rx_tlast;
  word_t [PORT_COUNT-1:0] data_tdata;
  keep_t [PORT_COUNT-1:0] data_tkeep;
  dest_t [PORT_COUNT-1:0] data_tdest;
  port_id_t [PORT_COUNT-1:0] data_tuser;
  logic [PORT_COUNT-1:0]  data_tvalid;
  logic [PORT_COUNT-1:0]  data_tready;
  logic [PORT_COUNT-1:0]  data_tlast;
  word_t                  ctrl_in_tdata;
  logic                   ctrl_in_tvalid;
  logic                   ctrl_in_tready;
  core_id_t               ctrl_in_tuser;
  word_t                  ctrl_out_tdata;
  logic                   ctrl_out_tvalid;
  logic                   ctrl_out_tready;
  core_id_t               ctrl_out_tdest;

  // Reference model state
  slot_t pool_mem [CORE_COUNT][SLOT_COUNT];
  int    pool_n [CORE_COUNT];
  dest_t held [PORT_COUNT];
  logic  held_v [PORT_COUNT];

  word_t    exp_word [$];
  keep_t    exp_keep [$];
  logic     exp_last [$];
  dest_t    obs_dest [$];
  word_t    ctrl_word [$];
  core_id_t ctrl_dest [$];

  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int test_errors;
  int unsigned seed_val;

  initial clk = 1'b0;
  always #50 clk = ~clk;

  packet_scheduler #(
    .PORT_COUNT(PORT_COUNT),
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT),
    .LOOPBACK_DEPTH(16)
  ) u_dut (
    .clk             (clk),
    .rst             (rst),
    .rx_tdata        (rx_tdata),
    .rx_tkeep        (rx_tkeep),
    .rx_tvalid       (rx_tvalid),
    .rx_tready       (rx_tready),
    .rx_tlast        (rx_tlast),
    .data_tdata      (data_tdata),
    .data_tkeep      (data_tkeep),
    .data_tdest      (data_tdest),
    .data_tuser      (data_tuser),
    .data_tvalid     (data_tvalid),
    .data_tready     (data_tready),
    .data_tlast      (data_tlast),
    .ctrl_in_tdata   (ctrl_in_tdata),
    .ctrl_in_tvalid  (ctrl_in_tvalid),
    .ctrl_in_tready  (ctrl_in_tready),
    .ctrl_in_tuser   (ctrl_in_tuser),
    .ctrl_out_tdata  (ctrl_out_tdata),
    .ctrl_out_tvalid (ctrl_out_tvalid),
    .ctrl_out_tready (ctrl_out_tready),
    .ctrl_out_tdest  (ctrl_out_tdest)
  );

  task automatic check_word(input word_t got, input word_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: t=%0t %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_keep(input keep_t got, input keep_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: t=%0t %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_dest(input dest_t got, input dest_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: t=%0t %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_port(input port_id_t got, input port_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: t=%0t %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_core(input core_id_t got, input core_id_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: t=%0t %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error: t=%0t %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // Most-stocked core, lowest index on a tie, -1 when all pools are empty
  function automatic int best_core();
    int best;
    best = -1;
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (pool_n[c] > 0 && (best < 0 || pool_n[c] > pool_n[best])) begin
        best = c;
      end
    end
    return best;
  endfunction

  function automatic dest_t next_dest();
    int    c;
    dest_t d;
    c = best_core();
    d = {core_id_t'(c), pool_mem[c][0]};
    for (int i = 0; i < SLOT_COUNT - 1; i++) begin
      pool_mem[c][i] = pool_mem[c][i+1];
    end
    pool_n[c]--;
    return d;
  endfunction

  function automatic int model_total();
    int t;
    t = 0;
    for (int c = 0; c < CORE_COUNT; c++) begin
      t += pool_n[c];
    end
    return t;
  endfunction

  // Ports without a destination take one from the pools
  task automatic model_settle();
    for (int p = 0; p < PORT_COUNT; p++) begin
      if (!held_v[p] && best_core() >= 0) begin
        held[p]   = next_dest();
        held_v[p] = 1'b1;
      end
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    $display("=== FAIL ===");
    $finish;
  endtask

  task automatic ctrl_send(input core_id_t core, input word_t data);
    int n;
    n = 0;
    @(negedge clk);
    ctrl_in_tdata  = data;
    ctrl_in_tuser  = core;
    ctrl_in_tvalid = 1'b1;
    @(posedge clk);
    while (!ctrl_in_tready) begin
      n++;
      if (n > TIMEOUT) fail_timeout("control input acceptance");
      @(posedge clk);
    end
    @(negedge clk);
    ctrl_in_tvalid = 1'b0;
  endtask

  task automatic ctrl_reject(input logic [7:0] msg);
    word_t w;
    w = {$urandom, $urandom};
    w[63:MSG_TYPE_LSB] = msg;
    @(negedge clk);
    ctrl_in_tdata  = w;
    ctrl_in_tuser  = core_id_t'($urandom);
    ctrl_in_tvalid = 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_flag(ctrl_in_tready, 1'b0, "ctrl_in_tready for an unknown type");
    end
    @(negedge clk);
    ctrl_in_tvalid = 1'b0;
  endtask

  task automatic init_core(input int core, input int n);
    word_t w;
    int    k;
    w = '0;
    w[63:MSG_TYPE_LSB] = MSG_SLOT_INIT;
    w[2:0] = n[2:0];
    ctrl_send(core_id_t'(core), w);
    k = (n[2:0] > SLOT_COUNT) ? SLOT_COUNT : n[2:0];
    pool_n[core] = k;
    for (int i = 0; i < k; i++) begin
      pool_mem[core][i] = slot_t'(i + 1);
    end
    wait_cycles(10);
    model_settle();
  endtask

  task automatic free_slot(input int core, input int slot);
    word_t w;
    w = '0;
    w[63:MSG_TYPE_LSB] = MSG_SLOT_FREE;
    w[LEN_WIDTH +: $bits(slot_t)] = slot_t'(slot);
    w[15:0] = $urandom;
    ctrl_send(core_id_t'(core), w);
    pool_mem[core][pool_n[core]] = slot_t'(slot);
    pool_n[core]++;
    wait_cycles(10);
    model_settle();
  endtask

  task automatic drive_word(input int p, input logic last);
    word_t w;
    keep_t k;
    w = {$urandom, $urandom};
    k = $urandom;
    @(negedge clk);
    rx_tdata[p]  = w;
    rx_tkeep[p]  = k;
    rx_tlast[p]  = last;
    rx_tvalid[p] = 1'b1;
    exp_word.push_back(w);
    exp_keep.push_back(k);
    exp_last.push_back(last);
  endtask

  task automatic wait_xfer(input int p);
    int n;
    n = 0;
    @(posedge clk);
    while (!(rx_tvalid[p] && rx_tready[p])) begin
      n++;
      if (n > TIMEOUT) fail_timeout("receive transfer");
      @(posedge clk);
    end
  endtask

  task automatic end_frame(input int p);
    @(negedge clk);
    rx_tvalid[p] = 1'b0;
    rx_tlast[p]  = 1'b0;
  endtask

  task automatic send_frame(input int p, input int len);
    for (int i = 0; i < len; i++) begin
      drive_word(p, i == len - 1);
      wait_xfer(p);
    end
    end_frame(p);
  endtask

  task automatic stall_check(input int p, input int n);
    repeat (n) begin
      @(posedge clk);
      check_flag(rx_tready[p], 1'b0, "rx_tready while stalled");
    end
  endtask

  task automatic check_frame_dest(input dest_t exp);
    checks++;
    if (obs_dest.size() == 0) begin
      errors++;
      $display("a frame finished but no destination was seen at t=%0t", $time);
    end else begin
      check_dest(obs_dest.pop_front(), exp, "frame tdest");
    end
  endtask

  task automatic frame_checked(input int p, input int len);
    dest_t exp;
    exp = held[p];
    send_frame(p, len);
    held_v[p] = 1'b0;
    wait_cycles(10);
    model_settle();
    check_frame_dest(exp);
  endtask

  task automatic test_end(input string name);
    tests_run++;
    if (errors == test_errors) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - test_errors);
    end
    test_errors = errors;
  endtask

  // Compares every transfer on the data and control outputs
  always @(posedge clk) begin
    if (!rst) begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        if (data_tvalid[p] && data_tready[p]) begin
          if (exp_word.size() == 0) begin
            errors++;
            $display("a word came out on data port %0d without being sent", p);
          end else begin
            check_word(data_tdata[p], exp_word.pop_front(), "data tdata");
            check_keep(data_tkeep[p], exp_keep.pop_front(), "data tkeep");
            check_flag(data_tlast[p], exp_last.pop_front(), "data tlast");
            check_port(data_tuser[p], port_id_t'(p), "data tuser");
            if (data_tlast[p]) begin
              obs_dest.push_back(data_tdest[p]);
            end
          end
        end
      end
      if (ctrl_out_tvalid && ctrl_out_tready) begin
        ctrl_word.push_back(ctrl_out_tdata);
        ctrl_dest.push_back(ctrl_out_tdest);
      end
    end
  end

  initial begin
    int       n;
    int       p;
    dest_t    a;
    dest_t    b;
    dest_t    pair_lo;
    dest_t    pair_hi;
    dest_t    exp;
    word_t    lb_w [6];
    core_id_t lb_c [6];

    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_errors  = 0;
    seed_val     = $urandom(85);
    rst             = 1'b1;
    rx_tdata        = '0;
    rx_tkeep        = '0;
    rx_tvalid       = '0;
    rx_tlast        = '0;
    data_tready     = '1;
    ctrl_in_tdata   = '0;
    ctrl_in_tvalid  = 1'b0;
    ctrl_in_tuser   = '0;
    ctrl_out_tready = 1'b1;
    for (int c = 0; c < CORE_COUNT; c++) begin
      pool_n[c] = 0;
    end
    for (int q = 0; q < PORT_COUNT; q++) begin
      held_v[q] = 1'b0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    n = 0;
    while (ctrl_word.size() < CORE_COUNT) begin
      n++;
      if (n > TIMEOUT) fail_timeout("reset command output");
      @(posedge clk);
    end
    wait_cycles(10);
    checks++;
    if (ctrl_word.size() != CORE_COUNT) begin
      errors++;
      $display("expected %0d reset commands but saw %0d", CORE_COUNT, ctrl_word.size());
    end
    for (int i = 0; i < CORE_COUNT; i++) begin
      check_core(ctrl_dest[i], core_id_t'(i), "reset command tdest");
      check_word(ctrl_word[i], {{63{1'b1}}, 1'b0}, "reset command tdata");
    end
    check_flag(ctrl_out_tvalid, 1'b0, "ctrl_out_tvalid after reset commands");
    ctrl_word.delete();
    ctrl_dest.delete();
    test_end("reset commands");

    // Both ports are empty here, so their first pair of slots may come in either order
    init_core(0, 4);
    pair_lo = held[0];
    pair_hi = held[1];
    send_frame(0, 1);
    held_v[0] = 1'b0;
    wait_cycles(10);
    model_settle();
    send_frame(1, 1);
    held_v[1] = 1'b0;
    wait_cycles(10);
    model_settle();
    checks++;
    if (obs_dest.size() < 2) begin
      errors++;
      $display("the first two frames did not both finish");
    end else begin
      a = obs_dest.pop_front();
      b = obs_dest.pop_front();
      check_dest((a < b) ? a : b, pair_lo, "first slot pair, lower");
      check_dest((a < b) ? b : a, pair_hi, "first slot pair, upper");
    end
    for (int c = 1; c < CORE_COUNT; c++) begin
      init_core(c, $urandom % 8);
    end
    for (int i = 0; i < 8; i++) begin
      p = i % 2;
      if (held_v[p] && model_total() > 0) frame_checked(p, 1 + $urandom % 3);
    end
    // Core 0 still holds used slots when it is set up again
    init_core(0, 4);
    frame_checked(0, 1);
    init_core(0, 1 + $urandom % 4);
    for (int i = 0; i < 4; i++) begin
      p = i % 2;
      if (held_v[p] && model_total() > 0) frame_checked(p, 1 + $urandom % 3);
    end
    test_end("slot init and selection");

    for (int c = 0; c < CORE_COUNT; c++) begin
      init_core(c, 0);
    end
    free_slot(2, 3);
    free_slot(2, 1);
    free_slot(1, 4);
    free_slot(3, 2);
    free_slot(3, 4);
    for (int i = 0; i < 6; i++) begin
      p = i % 2;
      if (held_v[p] && model_total() > 0) frame_checked(p, 1);
    end
    test_end("slot free");

    // Words of an unknown type are never taken
    ctrl_reject(8'h02);
    ctrl_reject(8'h80);
    @(negedge clk);
    ctrl_out_tready = 1'b0;
    for (int i = 0; i < 6; i++) begin
      lb_w[i] = {$urandom, $urandom};
      lb_w[i][63:MSG_TYPE_LSB] = MSG_LOOPBACK;
      lb_c[i] = core_id_t'($urandom);
      ctrl_send(lb_c[i], lb_w[i]);
    end
    wait_cycles(10);
    checks++;
    if (ctrl_word.size() != 0) begin
      errors++;
      $display("loopback words left while ctrl_out_tready was low");
    end
    @(negedge clk);
    ctrl_out_tready = 1'b1;
    n = 0;
    while (ctrl_word.size() < 6) begin
      n++;
      if (n > TIMEOUT) fail_timeout("loopback output");
      @(posedge clk);
    end
    wait_cycles(5);
    for (int i = 0; i < 6; i++) begin
      check_word(ctrl_word[i], {8'h00, lb_w[i][55:0]}, "loopback tdata");
      check_core(ctrl_dest[i], lb_c[i], "loopback tdest");
    end
    ctrl_word.delete();
    ctrl_dest.delete();
    test_end("loopback");

    for (int c = 0; c < CORE_COUNT; c++) begin
      init_core(c, 4);
    end
    for (int i = 0; i < 6; i++) begin
      frame_checked(i % 2, 2 + $urandom % 4);
    end
    @(negedge clk);
    data_tready[1] = 1'b0;
    exp = held[1];
    drive_word(1, 1'b1);
    stall_check(1, 8);
    @(negedge clk);
    data_tready[1] = 1'b1;
    wait_xfer(1);
    end_frame(1);
    held_v[1] = 1'b0;
    wait_cycles(10);
    model_settle();
    check_frame_dest(exp);
    test_end("frame passthrough");

    // Drain every pool through port 0 while port 1 keeps its destination
    n = 0;
    while (held_v[0]) begin
      n++;
      if (n > 40) fail_timeout("pool exhaustion");
      frame_checked(0, 1);
    end
    drive_word(0, 1'b1);
    stall_check(0, 20);
    free_slot(1, 2);
    exp = held[0];
    n = 0;
    while (obs_dest.size() == 0) begin
      n++;
      if (n > TIMEOUT) fail_timeout("frame after slot free");
      @(posedge clk);
    end
    end_frame(0);
    held_v[0] = 1'b0;
    model_settle();
    check_frame_dest(exp);
    test_end("exhaustion");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* rtl/core_reset_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module core_reset_seq #(
  parameter int CORE_COUNT = 4
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                lb_valid,
  input  sched_pkg::word_t    lb_data,
  input  sched_pkg::core_id_t lb_core,
  output logic                lb_ready,
  output logic                out_tvalid,
  output sched_pkg::word_t    out_tdata,
  output sched_pkg::core_id_t out_tdest,
  input  logic                out_tready
);

  import sched_pkg::*;

  logic [$bits(core_id_t):0] sent;
  logic                      in_reset;

  assign in_reset = (sent < CORE_COUNT);

  always_ff @(posedge clk) begin
    if (rst) begin
      sent <= '0;
    end else if (in_reset && out_tready) begin
      sent <= sent + 1'b1;
    end
  end

  // Loopback waits until every core got its reset command
  assign lb_ready   = !in_reset && out_tready;
  assign out_tvalid = in_reset || lb_valid;
  assign out_tdest  = in_reset ? core_id_t'(sent) : lb_core;

  // Type byte cleared so the core sends the descriptor out
  assign out_tdata = in_reset ? CORE_RESET_WORD : {8'h00, lb_data[MSG_TYPE_LSB-1:0]};

endmodule

`default_nettype wire

/* rtl/core_selector.sv */
`timescale 1ns/1ps
`default_nettype none

module core_selector #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 4
) (
  input  sched_pkg::slot_t [CORE_COUNT-1:0] counts,
  output sched_pkg::core_id_t               best,
  output logic                              any
);

  import sched_pkg::*;

  slot_t best_cnt;

  assign any = (counts != '0);

  always_comb begin
    best     = '0;
    best_cnt = counts[0];
    for (int i = 1; i < CORE_COUNT; i++) begin
      // Strict compare keeps the lowest index on a tie, a full pool cannot be beaten
      if (best_cnt != slot_t'(SLOT_COUNT) && counts[i] > best_cnt) begin
        best     = core_id_t'(i);
        best_cnt = counts[i];
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/desc_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clear,
  input  logic                       in_valid,
  input  logic [WIDTH-1:0]           in_data,
  output logic                       in_ready,
  output logic                       out_valid,
  output logic [WIDTH-1:0]           out_data,
  input  logic                       out_ready,
  output logic [$clog2(DEPTH+1)-1:0] count
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic             push;
  logic             pop;

  assign in_ready  = (count != DEPTH[$clog2(DEPTH+1)-1:0]);
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push && !clear) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leaves the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/packet_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_scheduler #(
  parameter int PORT_COUNT     = 2,
  parameter int CORE_COUNT     = 4,
  parameter int SLOT_COUNT     = 4,
  parameter int LOOPBACK_DEPTH = 16
) (
  input  logic                                 clk,
  input  logic                                 rst,

  input  sched_pkg::word_t [PORT_COUNT-1:0]    rx_tdata,
  input  sched_pkg::keep_t [PORT_COUNT-1:0]    rx_tkeep,
  input  logic [PORT_COUNT-1:0]                rx_tvalid,
  output logic [PORT_COUNT-1:0]                rx_tready,
  input  logic [PORT_COUNT-1:0]                rx_tlast,

  output sched_pkg::word_t [PORT_COUNT-1:0]    data_tdata,
  output sched_pkg::keep_t [PORT_COUNT-1:0]    data_tkeep,
  output sched_pkg::dest_t [PORT_COUNT-1:0]    data_tdest,
  output sched_pkg::port_id_t [PORT_COUNT-1:0] data_tuser,
  output logic [PORT_COUNT-1:0]                data_tvalid,
  input  logic [PORT_COUNT-1:0]                data_tready,
  output logic [PORT_COUNT-1:0]                data_tlast,

  input  sched_pkg::word_t                     ctrl_in_tdata,
  input  logic                                 ctrl_in_tvalid,
  output logic                                 ctrl_in_tready,
  input  sched_pkg::core_id_t                  ctrl_in_tuser,

  output sched_pkg::word_t                     ctrl_out_tdata,
  output logic                                 ctrl_out_tvalid,
  input  logic                                 ctrl_out_tready,
  output sched_pkg::core_id_t                  ctrl_out_tdest
);

  import sched_pkg::*;

  msg_type_t              msg_type;
  logic                   ctrl_accept;
  slot_t                  free_slot;
  slot_t                  init_count;

  logic [CORE_COUNT-1:0]  pool_clear;
  logic [CORE_COUNT-1:0]  load_valid;
  slot_t                  load_slot;
  logic                   loader_ready;

  logic [CORE_COUNT-1:0]  pool_in_ready;
  logic [CORE_COUNT-1:0]  pool_free_ok;
  slot_t [CORE_COUNT-1:0] pool_head;
  slot_t [CORE_COUNT-1:0] pool_count;
  core_id_t               best_core;
  logic                   any_slot;
  logic                   desc_pop;

  logic                   lb_in_ready;
  logic                   lb_valid;
  logic                   lb_ready;
  word_t                  lb_data;
  core_id_t               lb_core;

  assign msg_type    = msg_type_t'(ctrl_in_tdata[63:MSG_TYPE_LSB]);
  assign free_slot   = ctrl_in_tdata[LEN_WIDTH +: $bits(slot_t)];
  assign init_count  = ctrl_in_tdata[$bits(slot_t)-1:0];
  assign ctrl_accept = ctrl_in_tvalid && ctrl_in_tready;

  always_comb begin
    case (msg_type)
      MSG_SLOT_FREE: ctrl_in_tready = pool_free_ok[ctrl_in_tuser];
      MSG_LOOPBACK:  ctrl_in_tready = lb_in_ready;
      MSG_SLOT_INIT: ctrl_in_tready = loader_ready;
      default:       ctrl_in_tready = 1'b0;
    endcase
  end

  slot_loader #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) u_loader (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (ctrl_in_tvalid && (msg_type == MSG_SLOT_INIT)),
    .req_core   (ctrl_in_tuser),
    .req_count  (init_count),
    .req_ready  (loader_ready),
    .clear      (pool_clear),
    .load_valid (load_valid),
    .load_slot  (load_slot)
  );

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_pool
    logic free_push;

    assign free_push = ctrl_accept && (msg_type == MSG_SLOT_FREE) &&
                       (ctrl_in_tuser == core_id_t'(c));
    // Slot free is held off while the loader owns this pool
    assign pool_free_ok[c] = pool_in_ready[c] && !(pool_clear[c] || load_valid[c]);

    desc_fifo #(
      .WIDTH($bits(slot_t)),
      .DEPTH(SLOT_COUNT)
    ) u_pool (
      .clk       (clk),
      .rst       (rst),
      .clear     (pool_clear[c]),
      .in_valid  (load_valid[c] || free_push),
      .in_data   (load_valid[c] ? load_slot : free_slot),
      .in_ready  (pool_in_ready[c]),
      .out_valid (),
      .out_data  (pool_head[c]),
      .out_ready (desc_pop && (best_core == core_id_t'(c))),
      .count     (pool_count[c])
    );
  end

  core_selector #(
    .CORE_COUNT(CORE_COUNT),
    .SLOT_COUNT(SLOT_COUNT)
  ) u_selector (
    .counts (pool_count),
    .best   (best_core),
    .any    (any_slot)
  );

  port_tagger #(
    .PORT_COUNT(PORT_COUNT)
  ) u_tagger (
    .clk         (clk),
    .rst         (rst),
    .rx_tvalid   (rx_tvalid),
    .rx_tlast    (rx_tlast),
    .rx_tready   (rx_tready),
    .down_tready (data_tready),
    .down_tvalid (data_tvalid),
    .desc_valid  (any_slot),
    .desc        ({best_core, pool_head[best_core]}),
    .desc_pop    (desc_pop),
    .tdest       (data_tdest),
    .tuser       (data_tuser)
  );

  // Frame payload goes straight through
  assign data_tdata = rx_tdata;
  assign data_tkeep = rx_tkeep;
  assign data_tlast = rx_tlast;

  desc_fifo #(
    .WIDTH($bits(core_id_t) + $bits(word_t)),
    .DEPTH(LOOPBACK_DEPTH)
  ) u_loopback (
    .clk       (clk),
    .rst       (rst),
    .clear     (1'b0),
    .in_valid  (ctrl_accept && (msg_type == MSG_LOOPBACK)),
    .in_data   ({ctrl_in_tuser, ctrl_in_tdata}),
    .in_ready  (lb_in_ready),
    .out_valid (lb_valid),
    .out_data  ({lb_core, lb_data}),
    .out_ready (lb_ready),
    .count     ()
  );

  core_reset_seq #(
    .CORE_COUNT(CORE_COUNT)
  ) u_reset_seq (
    .clk        (clk),
    .rst        (rst),
    .lb_valid   (lb_valid),
    .lb_data    (lb_data),
    .lb_core    (lb_core),
    .lb_ready   (lb_ready),
    .out_tvalid (ctrl_out_tvalid),
    .out_tdata  (ctrl_out_tdata),
    .out_tdest  (ctrl_out_tdest),
    .out_tready (ctrl_out_tready)
  );

endmodule

`default_nettype wire

/* rtl/port_tagger.sv */
`timescale 1ns/1ps
`default_nettype none

module port_tagger #(
  parameter int PORT_COUNT = 2
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [PORT_COUNT-1:0]                rx_tvalid,
  input  logic [PORT_COUNT-1:0]                rx_tlast,
  output logic [PORT_COUNT-1:0]                rx_tready,
  input  logic [PORT_COUNT-1:0]                down_tready,
  output logic [PORT_COUNT-1:0]                down_tvalid,
  input  logic                                 desc_valid,
  input  sched_pkg::dest_t                     desc,
  output logic                                 desc_pop,
  output sched_pkg::dest_t [PORT_COUNT-1:0]    tdest,
  output sched_pkg::port_id_t [PORT_COUNT-1:0] tuser
);

  import sched_pkg::*;

  dest_t [PORT_COUNT-1:0] dest_r;
  logic  [PORT_COUNT-1:0] dest_v;
  logic  [PORT_COUNT-1:0] last_xfer;
  logic  [PORT_COUNT-1:0] req;
  port_id_t               rr_ptr;
  port_id_t               grant_idx;
  logic                   grant_valid;

  assign last_xfer = rx_tvalid & rx_tlast & rx_tready;
  // Prefetch the next destination while the last word goes out
  assign req       = ~dest_v | last_xfer;

  always_comb begin
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int k = 0; k < PORT_COUNT; k++) begin
      if (!grant_valid && req[(int'(rr_ptr) + k) % PORT_COUNT]) begin
        grant_valid = 1'b1;
        grant_idx   = port_id_t'((int'(rr_ptr) + k) % PORT_COUNT);
      end
    end
  end

  assign desc_pop = grant_valid && desc_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      dest_v <= '0;
      rr_ptr <= '0;
    end else begin
      dest_v <= dest_v & ~last_xfer;
      if (grant_valid) begin
        // Empty pools leave the port without a destination
        dest_v[grant_idx] <= desc_valid;
        rr_ptr <= (int'(grant_idx) == PORT_COUNT - 1) ? '0 : grant_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant_valid) begin
      dest_r[grant_idx] <= desc;
    end
  end

  assign rx_tready   = down_tready & dest_v;
  assign down_tvalid = rx_tvalid & dest_v;
  assign tdest       = dest_r;

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_tuser
    assign tuser[p] = port_id_t'(p);
  end

endmodule

`default_nettype wire

/* rtl/sched_pkg.sv */
`default_nettype none

package sched_pkg;

  typedef logic [1:0]  core_id_t;
  // Slots count from 1, hence one bit more than four slots need
  typedef logic [2:0]  slot_t;
  typedef logic [0:0]  port_id_t;
  // Core number in the upper bits, slot in the lower bits
  typedef logic [4:0]  dest_t;
  typedef logic [63:0] word_t;
  typedef logic [7:0]  keep_t;

  // Message type lives in the top byte of a control word
  typedef enum logic [7:0] {
    MSG_SLOT_FREE = 8'd0,
    MSG_LOOPBACK  = 8'd1,
    MSG_SLOT_INIT = 8'd4
  } msg_type_t;

  localparam int MSG_TYPE_LSB = 56;

  // Start of the slot field in a slot free message
  localparam int LEN_WIDTH = 16;

  localparam word_t CORE_RESET_WORD = 64'hFFFF_FFFF_FFFF_FFFE;

endpackage

`default_nettype wire

/* rtl/slot_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_loader #(
  parameter int CORE_COUNT = 4,
  parameter int SLOT_COUNT = 4
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req_valid,
  input  sched_pkg::core_id_t   req_core,
  input  sched_pkg::slot_t      req_count,
  output logic                  req_ready,
  output logic [CORE_COUNT-1:0] clear,
  output logic [CORE_COUNT-1:0] load_valid,
  output sched_pkg::slot_t      load_slot
);

  import sched_pkg::*;

  typedef enum logic [1:0] {IDLE, CLEAR, FILL} state_t;

  state_t   state;
  core_id_t core_r;
  slot_t    count_r;
  slot_t    slot_r;

  assign req_ready = (state == IDLE);
  assign load_slot = slot_r;

  always_comb begin
    clear      = '0;
    load_valid = '0;
    if (state == CLEAR) begin
      clear[core_r] = 1'b1;
    end
    if (state == FILL) begin
      load_valid[core_r] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE:    if (req_valid) state <= CLEAR;
        // An init of zero slots only empties the pool
        CLEAR:   state <= (count_r == '0) ? IDLE : FILL;
        FILL:    if (slot_r == count_r) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && req_valid) begin
      core_r  <= req_core;
      count_r <= (req_count > slot_t'(SLOT_COUNT)) ? slot_t'(SLOT_COUNT) : req_count;
    end
    if (state == CLEAR) begin
      slot_r <= slot_t'(1);
    end else if (state == FILL) begin
      slot_r <= slot_r + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* sources.f */
rtl/sched_pkg.sv
rtl/desc_fifo.sv
rtl/slot_loader.sv
rtl/core_reset_seq.sv
rtl/core_selector.sv
rtl/port_tagger.sv
rtl/packet_scheduler.sv
bench/sched_assert.sv
bench/tb_packet_scheduler.sv
